//--- hdl/hbus_beat_engine.sv
`default_nettype none

`include "hbus_config.svh"

module hbus_beat_engine (
  input  wire logic                        wb_clk,
  input  wire logic                        wb_rst,
  input  wire logic                        cmd_valid_i,
  input  wire hbus_pkg::hbus_cmd_t         cmd_i,
  input  wire logic                        rsp_full_i,
  input  wire logic                        hbus_ack_i,
  input  wire logic [15:0]                 hbus_dat_i,
  output      logic                        cmd_pop_o,
  output      logic                        rsp_push_o,
  output      hbus_pkg::hbus_rsp_t         rsp_o,
  output      logic                        hbus_req_o,
  output      logic                        hbus_we_o,
  output      logic [`HBUS_MEM_ADDR_W-1:0] hbus_adr_o,
  output      logic [15:0]                 hbus_dat_o,
  output      logic [1:0]                  hbus_mask_o
);

  hbus_pkg::hbus_eng_state_t state;
  hbus_pkg::hbus_cmd_t       cmd_q;
  logic                      beat;                        // 0 = low halfword
  logic [31:0]               rdata_q;

  // Hold off while a response push is still in flight so its slot is counted
  assign cmd_pop_o = (state == hbus_pkg::ENG_IDLE) & cmd_valid_i & ~rsp_full_i & ~rsp_push_o;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Four-phase beat sequencer
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state      <= hbus_pkg::ENG_IDLE;
      beat       <= 1'b0;
      hbus_req_o <= 1'b0;
      rsp_push_o <= 1'b0;
    end else begin
      rsp_push_o <= 1'b0;

      case (state)
        hbus_pkg::ENG_IDLE: begin
          if (cmd_pop_o) begin
            beat       <= 1'b0;
            hbus_req_o <= 1'b1;                           // Outputs settle with req
            state      <= hbus_pkg::ENG_REQUEST;
          end
        end

        hbus_pkg::ENG_REQUEST: begin
          if (hbus_ack_i) begin
            hbus_req_o <= 1'b0;
            state      <= hbus_pkg::ENG_RELEASE;
          end
        end

        hbus_pkg::ENG_RELEASE: begin
          if (!hbus_ack_i) begin
            if (beat) begin
              rsp_push_o <= 1'b1;
              state      <= hbus_pkg::ENG_IDLE;
            end else begin
              beat  <= 1'b1;                              // Address moves before req
              state <= hbus_pkg::ENG_NEXT;
            end
          end
        end

        hbus_pkg::ENG_NEXT: begin
          hbus_req_o <= 1'b1;
          state      <= hbus_pkg::ENG_REQUEST;
        end

        default: state <= hbus_pkg::ENG_IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Command latch and read assembly
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wb_clk) begin
    if (cmd_pop_o) begin
      cmd_q <= cmd_i;
    end
    if (state == hbus_pkg::ENG_REQUEST && hbus_ack_i) begin
      if (beat) begin
        rdata_q[31:16] <= hbus_dat_i;
      end else begin
        rdata_q[15:0]  <= hbus_dat_i;
      end
    end
    if (state == hbus_pkg::ENG_RELEASE && !hbus_ack_i && beat) begin
      rsp_o.rdata <= cmd_q.we ? 32'h0 : rdata_q;          // Writes complete with zero
    end
  end

  assign hbus_we_o   = cmd_q.we;
  assign hbus_adr_o  = {cmd_q.addr, beat};                // Word times two plus beat
  assign hbus_dat_o  = beat ? cmd_q.wdata[31:16] : cmd_q.wdata[15:0];
  assign hbus_mask_o = beat ? cmd_q.mask[3:2] : cmd_q.mask[1:0];

endmodule

`default_nettype wire

//--- hdl/hbus_bridge_top.sv
`default_nettype none

`include "hbus_config.svh"

module hbus_bridge_top (
  input  wire logic                        wb_clk,
  input  wire logic                        wb_rst,
  input  wire logic                        wb_cyc_i,
  input  wire logic                        wb_stb_i,
  input  wire logic                        wb_we_i,
  input  wire logic [`HBUS_WB_ADDR_W-1:0]  wb_adr_i,
  input  wire logic [31:0]                 wb_dat_i,
  input  wire logic [3:0]                  wb_sel_i,
  output      logic [31:0]                 wb_dat_o,
  output      logic                        wb_ack_o,
  input  wire logic                        hbus_ack_i,
  input  wire logic [15:0]                 hbus_dat_i,
  output      logic                        hbus_req_o,
  output      logic                        hbus_we_o,
  output      logic [`HBUS_MEM_ADDR_W-1:0] hbus_adr_o,
  output      logic [15:0]                 hbus_dat_o,
  output      logic [1:0]                  hbus_mask_o
);

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Queue links
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  logic                cmd_push;
  logic                cmd_full;
  logic                cmd_valid;
  logic                cmd_pop;
  hbus_pkg::hbus_cmd_t cmd_in;
  hbus_pkg::hbus_cmd_t cmd_head;

  logic                rsp_push;
  logic                rsp_full;
  logic                rsp_valid;
  logic                rsp_pop;
  hbus_pkg::hbus_rsp_t rsp_in;
  hbus_pkg::hbus_rsp_t rsp_head;

  hbus_wb_slave u_wb_slave (
    .wb_clk      (wb_clk),
    .wb_rst      (wb_rst),
    .wb_cyc_i    (wb_cyc_i),
    .wb_stb_i    (wb_stb_i),
    .wb_we_i     (wb_we_i),
    .wb_adr_i    (wb_adr_i),
    .wb_dat_i    (wb_dat_i),
    .wb_sel_i    (wb_sel_i),
    .cmd_full_i  (cmd_full),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp_head),
    .wb_ack_o    (wb_ack_o),
    .wb_dat_o    (wb_dat_o),
    .cmd_push_o  (cmd_push),
    .cmd_o       (cmd_in),
    .rsp_pop_o   (rsp_pop)
  );

  hbus_queue #(.payload_t(hbus_pkg::hbus_cmd_t)) u_cmd_queue (
    .wb_clk  (wb_clk),
    .wb_rst  (wb_rst),
    .push_i  (cmd_push),
    .data_i  (cmd_in),
    .pop_i   (cmd_pop),
    .data_o  (cmd_head),
    .valid_o (cmd_valid),
    .full_o  (cmd_full)
  );

  hbus_queue #(.payload_t(hbus_pkg::hbus_rsp_t)) u_rsp_queue (
    .wb_clk  (wb_clk),
    .wb_rst  (wb_rst),
    .push_i  (rsp_push),
    .data_i  (rsp_in),
    .pop_i   (rsp_pop),
    .data_o  (rsp_head),
    .valid_o (rsp_valid),
    .full_o  (rsp_full)
  );

  hbus_beat_engine u_beat_engine (
    .wb_clk      (wb_clk),
    .wb_rst      (wb_rst),
    .cmd_valid_i (cmd_valid),
    .cmd_i       (cmd_head),
    .rsp_full_i  (rsp_full),
    .hbus_ack_i  (hbus_ack_i),
    .hbus_dat_i  (hbus_dat_i),
    .cmd_pop_o   (cmd_pop),
    .rsp_push_o  (rsp_push),
    .rsp_o       (rsp_in),
    .hbus_req_o  (hbus_req_o),
    .hbus_we_o   (hbus_we_o),
    .hbus_adr_o  (hbus_adr_o),
    .hbus_dat_o  (hbus_dat_o),
    .hbus_mask_o (hbus_mask_o)
  );

endmodule

`default_nettype wire

//--- hdl/hbus_config.svh
`ifndef HBUS_CONFIG_SVH
`define HBUS_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Bridge geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Wishbone byte address
`define HBUS_WB_ADDR_W 32

// Memory port halfword address, one bit wider than the word address
`define HBUS_MEM_ADDR_W 12

// Entries in each of the command and response queues
`define HBUS_QUEUE_DEPTH 4

`endif

//--- hdl/hbus_pkg.sv
`default_nettype none

`include "hbus_config.svh"

package hbus_pkg;

  // One queued Wishbone access
  typedef struct packed {
    logic                          we;     // 1 = write
    logic [`HBUS_MEM_ADDR_W-2:0]   addr;   // Word address
    logic [31:0]                   wdata;
    logic [3:0]                    mask;   // Inverted sel, high bit blocks the byte
  } hbus_cmd_t;

  // One completion, zero for writes
  typedef struct packed {
    logic [31:0] rdata;
  } hbus_rsp_t;

  typedef enum logic {
    SLV_IDLE,
    SLV_WAIT
  } hbus_slv_state_t;

  typedef enum logic [1:0] {
    ENG_IDLE,
    ENG_REQUEST,
    ENG_RELEASE,
    ENG_NEXT
  } hbus_eng_state_t;

endpackage

`default_nettype wire

//--- hdl/hbus_queue.sv
`default_nettype none

`include "hbus_config.svh"

module hbus_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  depth     = `HBUS_QUEUE_DEPTH
) (
  input  wire logic wb_clk,
  input  wire logic wb_rst,
  input  wire logic push_i,
  input  wire payload_t data_i,
  input  wire logic pop_i,
  output      payload_t data_o,
  output      logic valid_o,
  output      logic full_o
);

  localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
  localparam int cnt_w = $clog2(depth + 1);

  payload_t         mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & valid_o;

  always_ff @(posedge wb_clk) begin
    if (do_push) begin
      mem[wr_ptr] <= data_i;
    end
  end

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;  // Wrap
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;                          // Both or neither
      endcase
    end
  end

  assign data_o  = mem[rd_ptr];                           // Head entry
  assign valid_o = (count != '0);
  assign full_o  = (count == cnt_w'(depth));

endmodule

`default_nettype wire

//--- hdl/hbus_wb_slave.sv
`default_nettype none

`include "hbus_config.svh"

module hbus_wb_slave (
  input  wire logic                       wb_clk,
  input  wire logic                       wb_rst,
  input  wire logic                       wb_cyc_i,
  input  wire logic                       wb_stb_i,
  input  wire logic                       wb_we_i,
  input  wire logic [`HBUS_WB_ADDR_W-1:0] wb_adr_i,
  input  wire logic [31:0]                wb_dat_i,
  input  wire logic [3:0]                 wb_sel_i,
  input  wire logic                       cmd_full_i,
  input  wire logic                       rsp_valid_i,
  input  wire hbus_pkg::hbus_rsp_t        rsp_i,
  output      logic                       wb_ack_o,
  output      logic [31:0]                wb_dat_o,
  output      logic                       cmd_push_o,
  output      hbus_pkg::hbus_cmd_t        cmd_o,
  output      logic                       rsp_pop_o
);

  hbus_pkg::hbus_slv_state_t state;
  logic                      accept;

  // Ack still high means the master has not yet moved on from the last access
  assign accept = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~cmd_full_i;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Control
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wb_clk) begin
    if (wb_rst) begin
      state      <= hbus_pkg::SLV_IDLE;
      wb_ack_o   <= 1'b0;
      cmd_push_o <= 1'b0;
      rsp_pop_o  <= 1'b0;
    end else begin
      wb_ack_o   <= 1'b0;                                 // Single-cycle pulses
      cmd_push_o <= 1'b0;
      rsp_pop_o  <= 1'b0;

      case (state)
        hbus_pkg::SLV_IDLE: begin
          if (accept) begin
            cmd_push_o <= 1'b1;
            state      <= hbus_pkg::SLV_WAIT;
          end
        end

        hbus_pkg::SLV_WAIT: begin
          if (rsp_valid_i) begin
            wb_ack_o  <= 1'b1;
            rsp_pop_o <= 1'b1;                            // Pop lands with the ack
            state     <= hbus_pkg::SLV_IDLE;
          end
        end

        default: state <= hbus_pkg::SLV_IDLE;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Payload
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge wb_clk) begin
    if (state == hbus_pkg::SLV_IDLE && accept) begin
      cmd_o.we    <= wb_we_i;
      cmd_o.addr  <= wb_adr_i[`HBUS_MEM_ADDR_W:2];        // Drop byte offset
      cmd_o.wdata <= wb_dat_i;
      cmd_o.mask  <= ~wb_sel_i;
    end
    if (state == hbus_pkg::SLV_WAIT && rsp_valid_i) begin
      wb_dat_o <= rsp_i.rdata;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f vlog.f \
  --top-module tb_hbus_bridge -o tb_hbus_bridge \
  && ./obj_dir/tb_hbus_bridge > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "STATUS: FAIL" sim.log && exit 1 || exit 0

//--- tb/tb_hbus_bridge.sv
`default_nettype none

`include "hbus_config.svh"

module tb_hbus_bridge;

  timeunit 1ns;
  timeprecision 100ps;

  logic                        wb_clk;
  logic                        wb_rst;
  logic                        wb_cyc_i;
  logic                        wb_stb_i;
  logic                        wb_we_i;
  logic [`HBUS_WB_ADDR_W-1:0]  wb_adr_i;
  logic [31:0]                 wb_dat_i;
  logic [3:0]                  wb_sel_i;
  logic [31:0]                 wb_dat_o;
  logic                        wb_ack_o;
  logic                        hbus_ack_i;
  logic [15:0]                 hbus_dat_i;
  logic                        hbus_req_o;
  logic                        hbus_we_o;
  logic [`HBUS_MEM_ADDR_W-1:0] hbus_adr_o;
  logic [15:0]                 hbus_dat_o;
  logic [1:0]                  hbus_mask_o;

  logic [7:0]  ref_mem [0:(1<<(`HBUS_MEM_ADDR_W+1))-1];   // Byte view of the memory
  logic [31:0] lfsr_q = 32'h2c60;
  logic [31:0] exp_dat;
  logic        timed_out = 1'b0;
  int          err_cnt = 0;
  int          acc_cnt = 0;
  int          ack_cnt = 0;
  int          tests_failed = 0;

  hbus_bridge_top u_hbus_bridge_top (.*);

  tb_hbus_mem u_mem (
    .wb_clk (wb_clk), .wb_rst (wb_rst), .req_i (hbus_req_o), .we_i (hbus_we_o),
    .adr_i (hbus_adr_o), .dat_i (hbus_dat_o), .mask_i (hbus_mask_o),
    .ack_o (hbus_ack_i), .dat_o (hbus_dat_i)
  );

  initial begin
    wb_clk = 1'b0;
    forever #4 wb_clk = ~wb_clk;
  end

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel);
    int waited;
    waited = 0;
    if (we) begin
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) ref_mem[adr[12:0] + b] = dat[8*b +: 8];
      end
    end else begin
      exp_dat = {ref_mem[adr[12:0] + 3], ref_mem[adr[12:0] + 2],
                 ref_mem[adr[12:0] + 1], ref_mem[adr[12:0]]};
    end
    @(posedge wb_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= sel;
    do begin
      @(posedge wb_clk);
      waited++;
    end while (!wb_ack_o && waited < 2000);
    if (!wb_ack_o) begin
      $display("t=%0t timeout: no wb_ack_o for access at %h", $time, adr);
      timed_out = 1'b1;
      forever @(posedge wb_clk);
    end else begin
      wb_cyc_i <= 1'b0;
      wb_stb_i <= 1'b0;
      acc_cnt++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    repeat (2) @(negedge wb_clk);                         // Checks of the last ack settle
    if (err_cnt + u_mem.err_cnt != errs_before) begin
      tests_failed++;
      $display("test %s: failed", name);
    end else $display("test %s: ok", name);
  endtask

  always @(posedge wb_clk) begin
    if (wb_ack_o) ack_cnt++;
    if (timed_out) begin
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Checks
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_rdata: assert property (@(posedge wb_clk) disable iff (wb_rst)
    (wb_ack_o && !wb_we_i) |-> wb_dat_o == exp_dat)
    else begin
      err_cnt++;
      $display("FAILED t=%0t wb_dat_o got %h expected %h", $time, $sampled(wb_dat_o),
               $sampled(exp_dat));
    end

  a_ack_pulse: assert property (@(posedge wb_clk) disable iff (wb_rst)
    wb_ack_o |=> !wb_ack_o)
    else begin
      err_cnt++;
      $display("t=%0t wb_ack_o held longer than one cycle", $time);
    end

  a_ack_strobe: assert property (@(posedge wb_clk) disable iff (wb_rst)
    wb_ack_o |-> (wb_cyc_i && wb_stb_i))
    else begin
      err_cnt++;
      $display("t=%0t wb_ack_o without cyc and stb", $time);
    end

  a_reset_quiet: assert property (@(posedge wb_clk)
    (wb_rst || $fell(wb_rst)) |-> (!wb_ack_o && !hbus_req_o))
    else begin
      err_cnt++;
      $display("t=%0t ack or req active around reset", $time);
    end

  a_beat_adr: assert property (@(posedge wb_clk) disable iff (wb_rst)
    ($rose(hbus_req_o) && !hbus_adr_o[0]) |-> hbus_adr_o[`HBUS_MEM_ADDR_W-1:1] ==
                                              wb_adr_i[`HBUS_MEM_ADDR_W:2])
    else begin
      err_cnt++;
      $display("FAILED t=%0t hbus_adr_o got %h expected %h", $time, $sampled(hbus_adr_o),
               {$sampled(wb_adr_i[`HBUS_MEM_ADDR_W:2]), 1'b0});
    end

  initial begin
    int errs;
    logic [31:0] adr;
    for (int i = 0; i < (1 << (`HBUS_MEM_ADDR_W + 1)); i++) ref_mem[i] = 8'h00;
    wb_rst   = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    wb_sel_i = '0;
    exp_dat  = '0;
    repeat (16) @(posedge wb_clk);
    wb_rst <= 1'b0;

    errs = err_cnt + u_mem.err_cnt;
    wb_access(1'b1, 32'h0000_0010, 32'hdead_beef, 4'hf);
    wb_access(1'b0, 32'h0000_0010, 32'h0, 4'hf);
    report_test("full word write and read", errs);

    errs = err_cnt + u_mem.err_cnt;
    wb_access(1'b1, 32'h0000_0010, 32'h1234_5678, 4'b0101);
    wb_access(1'b0, 32'h0000_0010, 32'h0, 4'hf);
    wb_access(1'b1, 32'h0000_0024, 32'ha5c3_0f96, 4'b1000);
    wb_access(1'b0, 32'h0000_0024, 32'h0, 4'hf);
    report_test("partial byte select", errs);

    errs = err_cnt + u_mem.err_cnt;
    for (int n = 0; n < 64; n++) begin
      adr = 32'h400 + (take_bits(5) << 2);                // 32-word window
      wb_access(1'b1, adr, take_bits(32), 4'(take_bits(4)));
      adr = 32'h400 + (take_bits(5) << 2);
      wb_access(1'b0, adr, 32'h0, 4'hf);
    end
    report_test("random writes and reads", errs);

    errs = err_cnt + u_mem.err_cnt;
    repeat (4) @(negedge wb_clk);
    a_ack_count: assert (ack_cnt == acc_cnt)
      else begin
        err_cnt++;
        $display("FAILED t=%0t wb_ack_o pulses got %0d expected %0d", $time, ack_cnt,
                 acc_cnt);
      end
    report_test("one ack per access", errs);

    $display("tests: %0d failed, errors: %0d", tests_failed, err_cnt + u_mem.err_cnt);
    if (err_cnt + u_mem.err_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/tb_hbus_mem.sv
`default_nettype none

`include "hbus_config.svh"

module tb_hbus_mem (
  input  wire logic                        wb_clk,
  input  wire logic                        wb_rst,
  input  wire logic                        req_i,
  input  wire logic                        we_i,
  input  wire logic [`HBUS_MEM_ADDR_W-1:0] adr_i,
  input  wire logic [15:0]                 dat_i,
  input  wire logic [1:0]                  mask_i,
  output      logic                        ack_o,
  output      logic [15:0]                 dat_o
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [15:0]                 mem_q [0:(1<<`HBUS_MEM_ADDR_W)-1];
  logic [31:0]                 lfsr_q = 32'h2c60;
  logic [1:0]                  phase;                     // Idle, rise, high, fall
  logic [2:0]                  delay;
  logic                        odd_beat;
  logic [`HBUS_MEM_ADDR_W-1:0] first_adr;
  int                          err_cnt = 0;

  function automatic logic [2:0] pick_delay();
    logic [2:0] r;
    r = '0;
    for (int i = 0; i < 3; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'ha300_0000) : (lfsr_q >> 1);
      r = {r[1:0], lfsr_q[0]};
    end
    return r;
  endfunction

  always @(posedge wb_clk) begin
    if (wb_rst) begin
      ack_o    <= 1'b0;
      dat_o    <= '0;
      phase    <= 2'd0;
      delay    <= '0;
      odd_beat <= 1'b0;
      for (int i = 0; i < (1 << `HBUS_MEM_ADDR_W); i++) mem_q[i] <= '0;
    end else begin
      case (phase)
        2'd0: if (req_i) begin
          delay <= pick_delay();
          phase <= 2'd1;
          if (!odd_beat && adr_i[0]) begin
            err_cnt++;
            $display("t=%0t first beat went to odd halfword address %h", $time, adr_i);
          end
          if (odd_beat && adr_i != first_adr + 1'b1) begin
            err_cnt++;
            $display("FAILED t=%0t adr_i got %h expected %h", $time, adr_i,
                     first_adr + 1'b1);
          end
          first_adr <= adr_i;
          odd_beat  <= ~odd_beat;
        end
        2'd1: if (delay == 0) begin
          ack_o <= 1'b1;
          dat_o <= mem_q[adr_i];                          // Valid while ack high
          if (we_i) begin
            mem_q[adr_i] <= {mask_i[1] ? mem_q[adr_i][15:8] : dat_i[15:8],
                             mask_i[0] ? mem_q[adr_i][7:0]  : dat_i[7:0]};
          end
          phase <= 2'd2;
        end else delay <= delay - 1'b1;
        2'd2: if (!req_i) begin
          delay <= pick_delay();
          phase <= 2'd3;
        end
        default: if (delay == 0) begin
          ack_o <= 1'b0;
          phase <= 2'd0;
        end else delay <= delay - 1'b1;
      endcase
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Four-phase protocol rules
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

  a_req_fall: assert property (@(posedge wb_clk) disable iff (wb_rst)
    $fell(req_i) |-> $past(ack_o))
    else begin
      err_cnt++;
      $display("t=%0t req dropped before ack rose", $time);
    end

  a_req_rise: assert property (@(posedge wb_clk) disable iff (wb_rst)
    $rose(req_i) |-> !$past(ack_o))
    else begin
      err_cnt++;
      $display("t=%0t req rose while ack still high", $time);
    end

  a_req_stable: assert property (@(posedge wb_clk) disable iff (wb_rst)
    (req_i && $past(req_i)) |-> ($stable(we_i) && $stable(adr_i) && $stable(dat_i)
                                 && $stable(mask_i)))
    else begin
      err_cnt++;
      $display("t=%0t beat outputs moved while req high", $time);
    end

  a_ack_rise: assert property (@(posedge wb_clk) disable iff (wb_rst)
    $rose(ack_o) |-> $past(req_i))
    else begin
      err_cnt++;
      $display("t=%0t ack rose without req", $time);
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/hbus_pkg.sv
hdl/hbus_queue.sv
hdl/hbus_wb_slave.sv
hdl/hbus_beat_engine.sv
hdl/hbus_bridge_top.sv
tb/tb_hbus_mem.sv
tb/tb_hbus_bridge.sv
